//--- flist.f
rtl/rd_pkg.sv
rtl/axi_frs.sv
rtl/rd_addr_gen.sv
rtl/ram_reader.sv
rtl/pic_reader.sv
rtl/rmux.sv
rtl/rd_top.sv
test/tb_rd_top.sv

//--- rtl/axi_frs.sv
`timescale 1ns/1ps
`default_nettype none

module axi_frs #(
    parameter int dw_bus = 8
) (
    input  wire logic              clk,
    input  wire logic              rst_n,

    input  wire logic [dw_bus-1:0] m_data,
    input  wire logic              m_valid,
    output logic                   m_ready,

    output logic      [dw_bus-1:0] s_data,
    output logic                   s_valid,
    input  wire logic              s_ready
);

    // free when empty or when the held word leaves this cycle.
    assign m_ready = ~s_valid | s_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid <= 1'b0;
        end else if (m_ready) begin
            s_valid <= m_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m_valid && m_ready) begin
            s_data <= m_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pic_reader.sv
`timescale 1ns/1ps
`default_nettype none

module pic_reader import rd_pkg::*; #(
    parameter int aw = aw_def
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic          wr_en,
    input  wire logic [aw-1:0] wr_addr,
    input  wire pixel_t        wr_data,

    input  wire logic [aw-1:0] addr,
    input  wire logic          addr_first,
    input  wire logic          addr_last,
    input  wire logic          addr_valid,
    output logic               addr_ready,

    output pixel_t             data,
    output logic               data_first,
    output logic               data_last,
    output logic               data_valid,
    input  wire logic          data_ready
);

    pixel_t pic_mem [2**aw];           // one pixel per word.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pic_mem[wr_addr] <= wr_data;
        end
    end

    assign addr_ready = ~data_valid | data_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else if (addr_ready) begin
            data_valid <= addr_valid;
        end
    end

    // pixel read, burst markers follow it out.
    always_ff @(posedge clk) begin
        if (addr_valid && addr_ready) begin
            data       <= pic_mem[addr];
            data_first <= addr_first;
            data_last  <= addr_last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ram_reader.sv
`timescale 1ns/1ps
`default_nettype none

module ram_reader import rd_pkg::*; #(
    parameter int aw = aw_def
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic          wr_en,
    input  wire logic [aw-1:0] wr_addr,
    input  wire lanes_t        wr_data,

    input  wire logic [aw-1:0] addr,
    input  wire logic          addr_first,
    input  wire logic          addr_last,
    input  wire logic          addr_valid,
    output logic               addr_ready,

    output lanes_t             data,
    output logic               data_first,
    output logic               data_last,
    output logic               data_valid,
    input  wire logic          data_ready
);

    lanes_t mem [2**aw];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // output register is free or drains this cycle.
    assign addr_ready = ~data_valid | data_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else if (addr_ready) begin
            data_valid <= addr_valid;
        end
    end

    // flags ride along with the word.
    always_ff @(posedge clk) begin
        if (addr_valid && addr_ready) begin
            data       <= mem[addr];
            data_first <= addr_first;
            data_last  <= addr_last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rd_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rd_addr_gen import rd_pkg::*; #(
    parameter int aw = aw_def
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic [aw-1:0] cmd_base,
    input  wire len_t          cmd_len,
    input  wire info_t         cmd_info,
    input  wire logic          cmd_valid,
    output logic               cmd_ready,

    output logic      [aw-1:0] addr,
    output logic               addr_first,
    output logic               addr_last,
    output logic               addr_valid,
    input  wire logic          addr_ready,

    output info_t              info,
    input  wire logic          done
);

    typedef enum logic [1:0] {
        idle,
        issue,
        drain
    } state_t;

    state_t state;
    len_t   remain;                    // addresses left after the current one.

    // one command at a time; the next waits for rd_last.
    assign cmd_ready = (state == idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            addr_valid <= 1'b0;
            info       <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_valid) begin
                        state      <= issue;
                        addr_valid <= 1'b1;
                        info       <= cmd_info;     // held until done.
                    end
                end
                issue: begin
                    if (addr_ready && addr_last) begin
                        state      <= drain;
                        addr_valid <= 1'b0;
                    end
                end
                drain: begin
                    if (done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            addr       <= cmd_base;
            remain     <= cmd_len;
            addr_first <= 1'b1;
            addr_last  <= (cmd_len == '0);
        end else if (addr_valid && addr_ready && !addr_last) begin
            addr       <= addr + 1'b1;          // wraps at the memory size.
            remain     <= remain - 1'b1;
            addr_first <= 1'b0;
            addr_last  <= (remain == 8'd1);
        end
    end

endmodule

`default_nettype wire

//--- rtl/rd_pkg.sv
`default_nettype none

package rd_pkg;

    // ram word layout.
    localparam int dn = 8;             // lanes per ram word.
    localparam int dw = 8;             // bits per lane.

    // picture store word layout.
    localparam int dw0 = 16;           // one rgb565 pixel.

    localparam int ifw = 4;            // info word width.
    localparam int aw_def = 13;        // default address width.

    // eight lanes of eight bits, lane 0 in the low byte.
    typedef logic [dn*dw-1:0] lanes_t;

    // rgb565, red in the top five bits.
    typedef logic [dw0-1:0] pixel_t;

    // bit 3 picks the memory, bits 2:0 the channel count (0 = all).
    typedef logic [ifw-1:0] info_t;

    typedef logic [7:0] len_t;         // burst length minus one.

endpackage

`default_nettype wire

//--- rtl/rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module rd_top import rd_pkg::*; #(
    parameter int aw = aw_def
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic [aw-1:0] cmd_base,
    input  wire len_t          cmd_len,
    input  wire info_t         cmd_info,
    input  wire logic          cmd_valid,
    output logic               cmd_ready,

    output lanes_t             rd_data,
    output logic               rd_first,
    output logic               rd_last,
    output logic               rd_valid,
    input  wire logic          rd_ready,

    input  wire logic          ram_wr_en,
    input  wire logic [aw-1:0] ram_wr_addr,
    input  wire lanes_t        ram_wr_data,

    input  wire logic          pic_wr_en,
    input  wire logic [aw-1:0] pic_wr_addr,
    input  wire pixel_t        pic_wr_data
);

    logic [aw-1:0] addr;
    logic          addr_first;
    logic          addr_last;
    logic          addr_valid;
    logic          addr_ready;
    info_t         info;

    logic [aw-1:0] ram_addr;
    logic          ram_addr_first;
    logic          ram_addr_last;
    logic          ram_addr_valid;
    logic          ram_addr_ready;
    lanes_t        ram_data;
    logic          ram_data_first;
    logic          ram_data_last;
    logic          ram_data_valid;
    logic          ram_data_ready;

    logic [aw-1:0] pic_addr;
    logic          pic_addr_first;
    logic          pic_addr_last;
    logic          pic_addr_valid;
    logic          pic_addr_ready;
    pixel_t        pic_data;
    logic          pic_data_first;
    logic          pic_data_last;
    logic          pic_data_valid;
    logic          pic_data_ready;

    rd_addr_gen #(.aw(aw)) u_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_base   (cmd_base),
        .cmd_len    (cmd_len),
        .cmd_info   (cmd_info),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .addr       (addr),
        .addr_first (addr_first),
        .addr_last  (addr_last),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .info       (info),
        .done       (rd_valid & rd_ready & rd_last)  // end of the burst at the output.
    );

    ram_reader #(.aw(aw)) u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (ram_wr_en),
        .wr_addr    (ram_wr_addr),
        .wr_data    (ram_wr_data),
        .addr       (ram_addr),
        .addr_first (ram_addr_first),
        .addr_last  (ram_addr_last),
        .addr_valid (ram_addr_valid),
        .addr_ready (ram_addr_ready),
        .data       (ram_data),
        .data_first (ram_data_first),
        .data_last  (ram_data_last),
        .data_valid (ram_data_valid),
        .data_ready (ram_data_ready)
    );

    pic_reader #(.aw(aw)) u_pic (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (pic_wr_en),
        .wr_addr    (pic_wr_addr),
        .wr_data    (pic_wr_data),
        .addr       (pic_addr),
        .addr_first (pic_addr_first),
        .addr_last  (pic_addr_last),
        .addr_valid (pic_addr_valid),
        .addr_ready (pic_addr_ready),
        .data       (pic_data),
        .data_first (pic_data_first),
        .data_last  (pic_data_last),
        .data_valid (pic_data_valid),
        .data_ready (pic_data_ready)
    );

    rmux #(.aw(aw)) u_rmux (
        .clk           (clk),
        .rst_n         (rst_n),
        .info          (info),
        .m_addr        (addr),
        .m_addr_first  (addr_first),
        .m_addr_last   (addr_last),
        .m_addr_valid  (addr_valid),
        .m_addr_ready  (addr_ready),
        .s_addr0       (ram_addr),
        .s_addr_first0 (ram_addr_first),
        .s_addr_last0  (ram_addr_last),
        .s_addr_valid0 (ram_addr_valid),
        .s_addr_ready0 (ram_addr_ready),
        .s_addr1       (pic_addr),
        .s_addr_first1 (pic_addr_first),
        .s_addr_last1  (pic_addr_last),
        .s_addr_valid1 (pic_addr_valid),
        .s_addr_ready1 (pic_addr_ready),
        .m_data0       (ram_data),
        .m_data_first0 (ram_data_first),
        .m_data_last0  (ram_data_last),
        .m_data_valid0 (ram_data_valid),
        .m_data_ready0 (ram_data_ready),
        .m_data1       (pic_data),
        .m_data_first1 (pic_data_first),
        .m_data_last1  (pic_data_last),
        .m_data_valid1 (pic_data_valid),
        .m_data_ready1 (pic_data_ready),
        .s_data        (rd_data),
        .s_data_first  (rd_first),
        .s_data_last   (rd_last),
        .s_data_valid  (rd_valid),
        .s_data_ready  (rd_ready)
    );

endmodule

`default_nettype wire

//--- rtl/rmux.sv
`timescale 1ns/1ps
`default_nettype none

module rmux import rd_pkg::*; #(
    parameter int aw = aw_def
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire info_t         info,

    input  wire logic [aw-1:0] m_addr,
    input  wire logic          m_addr_first,
    input  wire logic          m_addr_last,
    input  wire logic          m_addr_valid,
    output logic               m_addr_ready,

    output logic      [aw-1:0] s_addr0,        // ram.
    output logic               s_addr_first0,
    output logic               s_addr_last0,
    output logic               s_addr_valid0,
    input  wire logic          s_addr_ready0,

    output logic      [aw-1:0] s_addr1,        // picture store.
    output logic               s_addr_first1,
    output logic               s_addr_last1,
    output logic               s_addr_valid1,
    input  wire logic          s_addr_ready1,

    input  wire lanes_t        m_data0,
    input  wire logic          m_data_first0,
    input  wire logic          m_data_last0,
    input  wire logic          m_data_valid0,
    output logic               m_data_ready0,

    input  wire pixel_t        m_data1,
    input  wire logic          m_data_first1,
    input  wire logic          m_data_last1,
    input  wire logic          m_data_valid1,
    output logic               m_data_ready1,

    output lanes_t             s_data,
    output logic               s_data_first,
    output logic               s_data_last,
    output logic               s_data_valid,
    input  wire logic          s_data_ready
);

    logic          mem_sel;
    logic          mem_sel_r;
    logic [2:0]    channel;
    logic [dn-1:0] channel_en;

    logic [aw+1:0] addr_bus;
    logic [aw+1:0] addr_bus0;
    logic [aw+1:0] addr_bus1;
    logic          addr_valid0;
    logic          addr_valid1;
    logic          addr_ready0;
    logic          addr_ready1;

    lanes_t        pic_lanes;
    lanes_t        data_sel;
    lanes_t        data_masked;
    logic          first_sel;
    logic          last_sel;
    logic          valid_sel;
    logic          ready_sel;
    logic [dn*dw+1:0] data_bus_in;
    logic [dn*dw+1:0] data_bus_out;

    assign mem_sel = info[3];
    assign channel = info[2:0];

    // address side, steered by the live info bit.
    assign addr_bus     = {m_addr, m_addr_first, m_addr_last};
    assign addr_valid0  = m_addr_valid & ~mem_sel;
    assign addr_valid1  = m_addr_valid & mem_sel;
    assign m_addr_ready = mem_sel ? addr_ready1 : addr_ready0;

    axi_frs #(.dw_bus(aw + 2)) u_frs_addr0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .m_data  (addr_bus),
        .m_valid (addr_valid0),
        .m_ready (addr_ready0),
        .s_data  (addr_bus0),
        .s_valid (s_addr_valid0),
        .s_ready (s_addr_ready0)
    );

    axi_frs #(.dw_bus(aw + 2)) u_frs_addr1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .m_data  (addr_bus),
        .m_valid (addr_valid1),
        .m_ready (addr_ready1),
        .s_data  (addr_bus1),
        .s_valid (s_addr_valid1),
        .s_ready (s_addr_ready1)
    );

    assign {s_addr0, s_addr_first0, s_addr_last0} = addr_bus0;
    assign {s_addr1, s_addr_first1, s_addr_last1} = addr_bus1;

    // return side uses a delayed copy so it lines up with reader data.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_sel_r <= 1'b0;
        end else begin
            mem_sel_r <= mem_sel;
        end
    end

    // lanes: blue, green, red, then zeros.
    assign pic_lanes = {{((dn - 3) * dw){1'b0}},
                        m_data1[15:11], 3'b000,
                        m_data1[10:5],  2'b00,
                        m_data1[4:0],   3'b000};

    assign data_sel      = mem_sel_r ? pic_lanes     : m_data0;
    assign first_sel     = mem_sel_r ? m_data_first1 : m_data_first0;
    assign last_sel      = mem_sel_r ? m_data_last1  : m_data_last0;
    assign valid_sel     = mem_sel_r ? m_data_valid1 : m_data_valid0;
    assign m_data_ready0 = ~mem_sel_r & ready_sel;
    assign m_data_ready1 = mem_sel_r & ready_sel;

    // channel count 0 keeps every lane.
    always_comb begin
        for (int i = 0; i < dn; i++) begin
            channel_en[i] = (channel == 3'd0) || (i < channel);
        end
    end

    for (genvar g = 0; g < dn; g++) begin : g_lane
        assign data_masked[g*dw +: dw] = channel_en[g] ? data_sel[g*dw +: dw] : '0;
    end

    assign data_bus_in = {data_masked, first_sel, last_sel};

    axi_frs #(.dw_bus(dn * dw + 2)) u_frs_data (
        .clk     (clk),
        .rst_n   (rst_n),
        .m_data  (data_bus_in),
        .m_valid (valid_sel),
        .m_ready (ready_sel),
        .s_data  (data_bus_out),
        .s_valid (s_data_valid),
        .s_ready (s_data_ready)
    );

    assign {s_data, s_data_first, s_data_last} = data_bus_out;

endmodule

`default_nettype wire

//--- test/tb_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rd_top import rd_pkg::*;;

    localparam int aw = 8;
    localparam int mem_words = 2**aw;
    localparam int clk_period = 100;

    // words read back by tests 1 to 5 at 20 cycles each.
    localparam int total_words = 16 + 7 * 8 + 2 * 16 + 32 + 4 * 8;
    localparam int watchdog_cycles = total_words * 20 + 2 * mem_words + 300;

    logic          clk;
    logic          rst_n;
    logic [aw-1:0] cmd_base;
    len_t          cmd_len;
    info_t         cmd_info;
    logic          cmd_valid;
    logic          cmd_ready;
    lanes_t        rd_data;
    logic          rd_first;
    logic          rd_last;
    logic          rd_valid;
    logic          rd_ready;
    logic          ram_wr_en;
    logic [aw-1:0] ram_wr_addr;
    lanes_t        ram_wr_data;
    logic          pic_wr_en;
    logic [aw-1:0] pic_wr_addr;
    pixel_t        pic_wr_data;

    lanes_t ram_copy [mem_words];      // what the ram should hold.
    pixel_t pic_copy [mem_words];
    integer seed;
    int     first_latency;             // edges from acceptance to first word.

    rd_top #(.aw(aw)) u_rd_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_base    (cmd_base),
        .cmd_len     (cmd_len),
        .cmd_info    (cmd_info),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .rd_data     (rd_data),
        .rd_first    (rd_first),
        .rd_last     (rd_last),
        .rd_valid    (rd_valid),
        .rd_ready    (rd_ready),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .pic_wr_en   (pic_wr_en),
        .pic_wr_addr (pic_wr_addr),
        .pic_wr_data (pic_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string test_name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s (%s): expected %h actual %h",
                     test_name, field, expected, actual);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // rgb565 to msb aligned blue, green and red lanes.
    function automatic lanes_t expand_pixel(input pixel_t p);
        lanes_t w;
        w        = '0;
        w[7:0]   = {p[4:0], 3'b000};
        w[15:8]  = {p[10:5], 2'b00};
        w[23:16] = {p[15:11], 3'b000};
        return w;
    endfunction

    function automatic lanes_t expected_word(input logic [aw-1:0] a, input info_t info);
        lanes_t w;
        w = info[3] ? expand_pixel(pic_copy[a]) : ram_copy[a];
        if (info[2:0] != 3'd0) begin
            for (int i = 0; i < dn; i++) begin
                if (i >= info[2:0]) begin
                    w[i*dw +: dw] = '0;
                end
            end
        end
        return w;
    endfunction

    task automatic load_memories;
        lanes_t rw;
        integer r;
        for (int i = 0; i < mem_words; i++) begin
            rw = {$random(seed), $random(seed)};
            r  = $random(seed);
            ram_copy[i] = rw;
            pic_copy[i] = r[15:0];
            ram_wr_en   <= 1'b1;
            ram_wr_addr <= i[aw-1:0];
            ram_wr_data <= rw;
            pic_wr_en   <= 1'b1;
            pic_wr_addr <= i[aw-1:0];
            pic_wr_data <= r[15:0];
            @(posedge clk);
        end
        ram_wr_en <= 1'b0;
        pic_wr_en <= 1'b0;
    endtask

    // returns on the edge where the command is taken.
    task automatic send_cmd(input logic [aw-1:0] base, input len_t len, input info_t info);
        cmd_base  <= base;
        cmd_len   <= len;
        cmd_info  <= info;
        cmd_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic run_burst(input string test_name, input logic [aw-1:0] base,
                             input len_t len, input info_t info, input bit stall);
        int     idx;
        int     waited;
        logic   done;
        integer r;
        send_cmd(base, len, info);
        idx    = 0;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            waited++;
            if (rd_valid && rd_ready) begin
                if (idx == 0) begin
                    first_latency = waited;
                end
                check_value(test_name, $sformatf("data word %0d", idx),
                            expected_word(base + idx[aw-1:0], info), rd_data);
                check_value(test_name, $sformatf("first flag word %0d", idx),
                            64'(idx == 0), 64'(rd_first));
                check_value(test_name, $sformatf("last flag word %0d", idx),
                            64'(idx == int'(len)), 64'(rd_last));
                done = rd_last;
                idx++;
            end
            if (stall) begin
                r = $random(seed);
                rd_ready <= r[0];
            end
        end
        rd_ready <= 1'b1;
    endtask

    task automatic test_ram_burst;
        run_burst("ram burst", 8'd16, 8'd15, 4'b0000, 1'b0);
        check_value("ram burst", "latency", 64'd4, 64'(first_latency));
    endtask

    task automatic test_ram_mask;
        for (int n = 1; n < 8; n++) begin
            run_burst($sformatf("ram mask %0d", n), 8'(n * 20), 8'd7,
                      {1'b0, 3'(n)}, 1'b0);
        end
    endtask

    task automatic test_pic_burst;
        run_burst("picture burst", 8'd248, 8'd15, 4'b1000, 1'b0);  // wraps past 255.
        run_burst("picture mask", 8'd60, 8'd15, 4'b1010, 1'b0);
    endtask

    task automatic test_back_pressure;
        run_burst("back pressure", 8'd100, 8'd31, 4'b0000, 1'b1);
    endtask

    task automatic test_alternating;
        run_burst("alternating ram", 8'd0, 8'd7, 4'b0000, 1'b0);
        run_burst("alternating pic", 8'd37, 8'd7, 4'b1000, 1'b0);
        run_burst("alternating ram masked", 8'd74, 8'd7, 4'b0011, 1'b0);
        run_burst("alternating pic", 8'd111, 8'd7, 4'b1000, 1'b0);
    endtask

    task automatic check_idle(input string test_name);
        check_value(test_name, "cmd_ready", 64'd1, 64'(cmd_ready));
        check_value(test_name, "rd_valid", 64'd0, 64'(rd_valid));
    endtask

    task automatic test_reset_state;
        // a burst stuck at the output gives reset something to clear.
        send_cmd(8'd200, 8'd15, 4'b0000);
        rd_ready <= 1'b0;
        repeat (6) @(posedge clk);
        check_value("reset busy", "cmd_ready", 64'd0, 64'(cmd_ready));
        check_value("reset busy", "rd_valid", 64'd1, 64'(rd_valid));
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        check_idle("reset held");
        rd_ready <= 1'b1;
        rst_n    <= 1'b1;
        @(posedge clk);
        check_idle("reset released");
    endtask

    initial begin
        seed        = 32'h4c272612;
        rst_n       = 1'b0;
        cmd_base    = '0;
        cmd_len     = '0;
        cmd_info    = '0;
        cmd_valid   = 1'b0;
        rd_ready    = 1'b1;
        ram_wr_en   = 1'b0;
        ram_wr_addr = '0;
        ram_wr_data = '0;
        pic_wr_en   = 1'b0;
        pic_wr_addr = '0;
        pic_wr_data = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle("power on");

        load_memories();
        test_ram_burst();
        test_ram_mask();
        test_pic_burst();
        test_back_pressure();
        test_alternating();
        test_reset_state();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
